//--- verilog/nird_pkg.sv
package nird_pkg;

  localparam int PIX_W  = 8;
  localparam int SUM_W  = 13;
  localparam int CODE_W = 4;
  localparam int SIZE_W = 9;

  // NI compares sample * GAIN against the patch sum, avoiding a divide.
  localparam int GAIN = 25;

  typedef logic [PIX_W-1:0] pixel_t;

  typedef logic [CODE_W-1:0] code_t;

  // Index 0 is the top row.
  typedef struct packed {
    pixel_t [0:4] px;
  } column_t;

  // Row-major, px[row][col], top-left first.
  typedef struct packed {
    pixel_t [0:4][0:4] px;
  } window_t;

  // Index 0 = east, then counter-clockwise in 45 degree steps.
  typedef struct packed {
    pixel_t [7:0]     r1;
    pixel_t [7:0]     r2;
    logic [SUM_W-1:0] sum;
  } ring_t;

  typedef struct packed {
    logic [7:0] ni;
    logic [7:0] rd;
  } pattern_t;

  typedef struct packed {
    logic valid;
    logic last;
  } beat_t;

endpackage

//--- verilog/nird_line_buffer.sv
`timescale 1ns/100ps

module nird_line_buffer #(
  parameter int MAX_SIZE = 64
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  nird_pkg::pixel_t              pixel_i,
  input  logic                          valid_i,
  input  logic [nird_pkg::SIZE_W-1:0]   img_size_i,
  output nird_pkg::column_t             column_o,
  output logic                          valid_o
);

  import nird_pkg::*;

  localparam int ADDR_W = $clog2(MAX_SIZE);

  // Entry 0 holds the previous row, entry 3 the row four lines up.
  pixel_t row_mem [4][MAX_SIZE];

  logic [ADDR_W-1:0] col_ptr;
  logic              col_wrap;

  assign col_wrap = (SIZE_W'(col_ptr) == img_size_i - SIZE_W'(1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_ptr <= '0;
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        if (col_wrap) begin
          col_ptr <= '0;
        end else begin
          col_ptr <= col_ptr + ADDR_W'(1);
        end
      end
    end
  end

  // Read the old rows and push the cascade down by one line.
  always_ff @(posedge clk) begin
    if (valid_i) begin
      row_mem[0][col_ptr] <= pixel_i;
      for (int k = 1; k < 4; k++) begin
        row_mem[k][col_ptr] <= row_mem[k-1][col_ptr];
      end
      column_o.px[0] <= row_mem[3][col_ptr];
      column_o.px[1] <= row_mem[2][col_ptr];
      column_o.px[2] <= row_mem[1][col_ptr];
      column_o.px[3] <= row_mem[0][col_ptr];
      column_o.px[4] <= pixel_i;
    end
  end

endmodule

//--- verilog/nird_window.sv
`timescale 1ns/100ps

module nird_window #(
  parameter int MAX_SIZE = 64
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  nird_pkg::column_t             column_i,
  input  logic                          valid_i,
  input  logic [nird_pkg::SIZE_W-1:0]   img_size_i,
  output nird_pkg::window_t             window_o,
  output nird_pkg::beat_t               beat_o
);

  import nird_pkg::*;

  logic [SIZE_W-1:0] row_cnt;
  logic [SIZE_W-1:0] col_cnt;
  logic [SIZE_W-1:0] last_idx;
  logic              row_end;
  logic              col_end;

  assign last_idx = img_size_i - SIZE_W'(1);
  assign row_end  = (row_cnt == last_idx);
  assign col_end  = (col_cnt == last_idx);

  // Position of the incoming column in the frame.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_cnt <= '0;
      col_cnt <= '0;
    end else if (valid_i) begin
      if (col_end) begin
        col_cnt <= '0;
        row_cnt <= row_end ? '0 : row_cnt + SIZE_W'(1);
      end else begin
        col_cnt <= col_cnt + SIZE_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_o <= '0;
    end else begin
      beat_o.valid <= valid_i && (row_cnt >= SIZE_W'(4)) && (col_cnt >= SIZE_W'(4));
      beat_o.last  <= valid_i && row_end && col_end;
    end
  end

  // Newest column enters on the right.
  always_ff @(posedge clk) begin
    if (valid_i) begin
      for (int r = 0; r < 5; r++) begin
        for (int c = 0; c < 4; c++) begin
          window_o.px[r][c] <= window_o.px[r][c+1];
        end
        window_o.px[r][4] <= column_i.px[r];
      end
    end
  end

  a_size_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_i |-> (img_size_i >= SIZE_W'(5)) && (img_size_i <= SIZE_W'(MAX_SIZE))
  );

endmodule

//--- verilog/nird_ring_sampler.sv
`timescale 1ns/100ps

module nird_ring_sampler (
  input  logic              clk,
  input  logic              rst_n,
  input  nird_pkg::window_t window_i,
  input  nird_pkg::beat_t   beat_i,
  output nird_pkg::ring_t   ring_o,
  output nird_pkg::beat_t   beat_o
);

  import nird_pkg::*;

  ring_t ring_d;

  function automatic pixel_t corner_avg(input pixel_t a, input pixel_t b,
                                        input pixel_t c, input pixel_t d);
    logic [PIX_W+1:0] total;
    total = {2'b00, a} + {2'b00, b} + {2'b00, c} + {2'b00, d};
    return total[PIX_W+1:2];
  endfunction

  always_comb begin
    // Radius 1, the eight neighbours of the centre at (2,2).
    ring_d.r1[0] = window_i.px[2][3];
    ring_d.r1[1] = window_i.px[1][3];
    ring_d.r1[2] = window_i.px[1][2];
    ring_d.r1[3] = window_i.px[1][1];
    ring_d.r1[4] = window_i.px[2][1];
    ring_d.r1[5] = window_i.px[3][1];
    ring_d.r1[6] = window_i.px[3][2];
    ring_d.r1[7] = window_i.px[3][3];

    // Radius 2, diagonals are the floor mean of the outer 2x2 corner.
    ring_d.r2[0] = window_i.px[2][4];
    ring_d.r2[1] = corner_avg(window_i.px[0][3], window_i.px[0][4],
                              window_i.px[1][3], window_i.px[1][4]);
    ring_d.r2[2] = window_i.px[0][2];
    ring_d.r2[3] = corner_avg(window_i.px[0][0], window_i.px[0][1],
                              window_i.px[1][0], window_i.px[1][1]);
    ring_d.r2[4] = window_i.px[2][0];
    ring_d.r2[5] = corner_avg(window_i.px[3][0], window_i.px[3][1],
                              window_i.px[4][0], window_i.px[4][1]);
    ring_d.r2[6] = window_i.px[4][2];
    ring_d.r2[7] = corner_avg(window_i.px[3][3], window_i.px[3][4],
                              window_i.px[4][3], window_i.px[4][4]);

    ring_d.sum = '0;
    for (int r = 0; r < 5; r++) begin
      for (int c = 0; c < 5; c++) begin
        ring_d.sum = ring_d.sum + SUM_W'(window_i.px[r][c]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_o <= '0;
    end else begin
      beat_o <= beat_i;
    end
  end

  always_ff @(posedge clk) begin
    ring_o <= ring_d;
  end

endmodule

//--- verilog/nird_pattern.sv
`timescale 1ns/100ps

module nird_pattern (
  input  logic               clk,
  input  logic               rst_n,
  input  nird_pkg::ring_t    ring_i,
  input  nird_pkg::beat_t    beat_i,
  output nird_pkg::pattern_t pattern_o,
  output nird_pkg::beat_t    beat_o
);

  import nird_pkg::*;

  logic [SUM_W-1:0] scaled [8];
  pattern_t         pattern_d;

  always_comb begin
    for (int k = 0; k < 8; k++) begin
      // Same as sample >= sum / 25 without the divide.
      scaled[k]       = SUM_W'(ring_i.r2[k]) * SUM_W'(GAIN);
      pattern_d.ni[k] = (scaled[k] >= ring_i.sum);
      pattern_d.rd[k] = (ring_i.r2[k] >= ring_i.r1[k]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_o <= '0;
    end else begin
      beat_o <= beat_i;
    end
  end

  always_ff @(posedge clk) begin
    pattern_o <= pattern_d;
  end

endmodule

//--- verilog/nird_riu2.sv
`timescale 1ns/100ps

module nird_riu2 (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [7:0]      bits_i,
  input  nird_pkg::beat_t beat_i,
  output nird_pkg::code_t code_o,
  output logic            valid_o,
  output logic            finish_o
);

  import nird_pkg::*;

  logic [7:0] edges;
  code_t      ones;
  code_t      code_d;

  // Bit k is compared with bit k+1 and bit 7 wraps to bit 0.
  assign edges  = bits_i ^ {bits_i[0], bits_i[7:1]};
  assign ones   = CODE_W'($countones(bits_i));
  assign code_d = ($countones(edges) <= 2) ? ones : CODE_W'(9);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_o  <= 1'b0;
      finish_o <= 1'b0;
    end else begin
      valid_o  <= beat_i.valid;
      finish_o <= beat_i.valid && beat_i.last;
    end
  end

  always_ff @(posedge clk) begin
    code_o <= code_d;
  end

  // A last beat always carries a valid window.
  a_last_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    beat_i.last |-> beat_i.valid
  );

endmodule

//--- verilog/nird_top.sv
`timescale 1ns/100ps

module nird_top #(
  parameter int MAX_SIZE = 64
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  nird_pkg::pixel_t              pixel_i,
  input  logic                          pixel_valid_i,
  input  logic [nird_pkg::SIZE_W-1:0]   img_size_i,
  output nird_pkg::code_t               ni_o,
  output nird_pkg::code_t               rd_o,
  output logic                          code_valid_o,
  output logic                          finish_o
);

  import nird_pkg::*;

  logic [SIZE_W-1:0] img_size;
  column_t           column;
  logic              column_valid;
  window_t           window;
  beat_t             window_beat;
  ring_t             ring;
  beat_t             ring_beat;
  pattern_t          pattern;
  beat_t             pattern_beat;

  // Size is held stable for a whole frame.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      img_size <= '0;
    end else begin
      img_size <= img_size_i;
    end
  end

  nird_line_buffer #(
    .MAX_SIZE (MAX_SIZE)
  ) u_line_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .pixel_i    (pixel_i),
    .valid_i    (pixel_valid_i),
    .img_size_i (img_size),
    .column_o   (column),
    .valid_o    (column_valid)
  );

  nird_window #(
    .MAX_SIZE (MAX_SIZE)
  ) u_window (
    .clk        (clk),
    .rst_n      (rst_n),
    .column_i   (column),
    .valid_i    (column_valid),
    .img_size_i (img_size),
    .window_o   (window),
    .beat_o     (window_beat)
  );

  nird_ring_sampler u_ring_sampler (
    .clk      (clk),
    .rst_n    (rst_n),
    .window_i (window),
    .beat_i   (window_beat),
    .ring_o   (ring),
    .beat_o   (ring_beat)
  );

  nird_pattern u_pattern (
    .clk       (clk),
    .rst_n     (rst_n),
    .ring_i    (ring),
    .beat_i    (ring_beat),
    .pattern_o (pattern),
    .beat_o    (pattern_beat)
  );

  nird_riu2 u_riu2_ni (
    .clk      (clk),
    .rst_n    (rst_n),
    .bits_i   (pattern.ni),
    .beat_i   (pattern_beat),
    .code_o   (ni_o),
    .valid_o  (code_valid_o),
    .finish_o (finish_o)
  );

  // Shares the NI beat, so its flags are not needed.
  nird_riu2 u_riu2_rd (
    .clk      (clk),
    .rst_n    (rst_n),
    .bits_i   (pattern.rd),
    .beat_i   (pattern_beat),
    .code_o   (rd_o),
    .valid_o  (),
    .finish_o ()
  );

endmodule

//--- dv/nird_tb.sv
`timescale 1ns/100ps

module nird_tb;

  import nird_pkg::*;

  localparam int  MAX_SIZE   = 64;
  localparam time PERIOD     = 40;
  // Drive edge to the falling edge after code_valid_o rises five cycles later.
  localparam time LATENCY_T  = 220;
  localparam int  DRAIN_MAX  = 200;
  localparam int  NUM_FRAMES = 8;

  localparam int KIND_CONST = 0;
  localparam int KIND_RAMP  = 1;
  localparam int KIND_CHECK = 2;
  localparam int KIND_RAND  = 3;

  typedef struct packed {
    logic [SIZE_W-1:0] side;
    logic [1:0]        kind;
    logic              gap;
  } frame_t;

  localparam frame_t FRAMES [NUM_FRAMES] = '{
    '{9'd5,  2'd0, 1'b0}, '{9'd12, 2'd0, 1'b1}, '{9'd10, 2'd1, 1'b0}, '{9'd9,  2'd2, 1'b1},
    '{9'd5,  2'd3, 1'b0}, '{9'd9,  2'd3, 1'b1}, '{9'd16, 2'd3, 1'b0}, '{9'd7,  2'd1, 1'b1}
  };

  // Ring directions, 0 is east, counter-clockwise, rows grow downward.
  localparam int DR [8] = '{0, -1, -1, -1, 0, 1, 1, 1};
  localparam int DC [8] = '{1, 1, 0, -1, -1, -1, 0, 1};

  logic              clk;
  logic              rst_n;
  pixel_t            pixel_i;
  logic              pixel_valid_i;
  logic [SIZE_W-1:0] img_size_i;
  code_t             ni_o;
  code_t             rd_o;
  logic              code_valid_o;
  logic              finish_o;

  pixel_t img [MAX_SIZE][MAX_SIZE];
  code_t  exp_ni [$];
  code_t  exp_rd [$];
  logic   exp_last [$];
  int     exp_frame [$];
  time    exp_time [$];
  int     out_cnt [NUM_FRAMES];
  int     fin_cnt [NUM_FRAMES];
  int     checks;
  int     errors;
  int     err_base;
  integer seed;

  nird_top #(
    .MAX_SIZE (MAX_SIZE)
  ) UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .img_size_i    (img_size_i),
    .ni_o          (ni_o),
    .rd_o          (rd_o),
    .code_valid_o  (code_valid_o),
    .finish_o      (finish_o)
  );

  always #(PERIOD / 2) clk = ~clk;

  function automatic string kind_name(input int kind);
    case (kind)
      KIND_CONST: return "constant";
      KIND_RAMP:  return "ramp";
      KIND_CHECK: return "checkerboard";
      default:    return "random";
    endcase
  endfunction

  function automatic int px(input int r, input int c);
    return int'(img[r][c]);
  endfunction

  function automatic code_t riu2_ref(input logic [7:0] b);
    int trans;
    int ones;
    trans = 0;
    ones  = 0;
    for (int k = 0; k < 8; k++) begin
      ones = ones + int'(b[k]);
      if (b[k] != b[(k + 1) % 8]) begin
        trans++;
      end
    end
    return (trans <= 2) ? code_t'(ones) : code_t'(9);
  endfunction

  task automatic check_code(input code_t got, input code_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_time(input time got, input time exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("mismatch at %0t: code came out at %0t, expected at %0t", $time, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic fill_image(input int side, input int kind);
    for (int r = 0; r < side; r++) begin
      for (int c = 0; c < side; c++) begin
        case (kind)
          KIND_CONST: img[r][c] = 8'd100;
          KIND_RAMP:  img[r][c] = pixel_t'(c * 23);
          KIND_CHECK: img[r][c] = ((r + c) % 2 == 0) ? 8'd200 : 8'd30;
          default:    img[r][c] = pixel_t'($random(seed));
        endcase
      end
    end
  endtask

  // Expected codes in raster order of the window's bottom-right pixel.
  task automatic build_expected(input int side, input int f);
    int         cr;
    int         cc;
    int         sum;
    int         r1;
    int         r2;
    logic [7:0] ni;
    logic [7:0] rd;
    for (int r = 4; r < side; r++) begin
      for (int c = 4; c < side; c++) begin
        cr  = r - 2;
        cc  = c - 2;
        sum = 0;
        for (int i = -2; i <= 2; i++) begin
          for (int j = -2; j <= 2; j++) begin
            sum = sum + px(cr + i, cc + j);
          end
        end
        for (int k = 0; k < 8; k++) begin
          r1 = px(cr + DR[k], cc + DC[k]);
          if (DR[k] == 0 || DC[k] == 0) begin
            r2 = px(cr + 2 * DR[k], cc + 2 * DC[k]);
          end else begin
            r2 = (px(cr + DR[k], cc + DC[k]) + px(cr + DR[k], cc + 2 * DC[k]) +
                  px(cr + 2 * DR[k], cc + DC[k]) + px(cr + 2 * DR[k], cc + 2 * DC[k])) / 4;
          end
          ni[k] = (r2 * GAIN >= sum);
          rd[k] = (r2 >= r1);
        end
        exp_ni.push_back(riu2_ref(ni));
        exp_rd.push_back(riu2_ref(rd));
        exp_last.push_back(r == side - 1 && c == side - 1);
        exp_frame.push_back(f);
      end
    end
  endtask

  task automatic run_frame(input int f);
    int side;
    int idle;
    side = int'(FRAMES[f].side);
    fill_image(side, int'(FRAMES[f].kind));
    build_expected(side, f);
    // Size changes one cycle before the first pixel.
    @(posedge clk);
    img_size_i    <= FRAMES[f].side;
    pixel_valid_i <= 1'b0;
    for (int r = 0; r < side; r++) begin
      for (int c = 0; c < side; c++) begin
        if (FRAMES[f].gap && (($random(seed) & 3) == 0)) begin
          idle = 1 + ($random(seed) & 1);
          repeat (idle) begin
            @(posedge clk);
            pixel_valid_i <= 1'b0;
          end
        end
        @(posedge clk);
        pixel_i       <= img[r][c];
        pixel_valid_i <= 1'b1;
        if (r >= 4 && c >= 4) begin
          exp_time.push_back($time + LATENCY_T);
        end
      end
    end
  endtask

  task automatic report_frame(input int f);
    int side;
    side = int'(FRAMES[f].side);
    check_count(out_cnt[f], (side - 4) * (side - 4), "code count");
    check_count(fin_cnt[f], 1, "finish pulses");
    $display("frame %0d size %0d %s: %0d codes, %0d errors", f, side,
             kind_name(int'(FRAMES[f].kind)), out_cnt[f], errors - err_base);
    err_base = errors;
  endtask

  always @(negedge clk) begin : monitor
    int    f;
    code_t e_ni;
    code_t e_rd;
    logic  e_last;
    time   e_time;
    if (rst_n === 1'b1) begin
      if (code_valid_o === 1'b1) begin
        if (exp_ni.size() == 0) begin
          errors++;
          $display("Unexpected code output at %0t with no window pending", $time);
        end else begin
          e_ni   = exp_ni.pop_front();
          e_rd   = exp_rd.pop_front();
          e_last = exp_last.pop_front();
          f      = exp_frame.pop_front();
          e_time = (exp_time.size() > 0) ? exp_time.pop_front() : 0;
          check_code(ni_o, e_ni, "NI code");
          check_code(rd_o, e_rd, "RD code");
          check_flag(finish_o, e_last, "finish_o");
          check_time($time, e_time);
          out_cnt[f]++;
          if (finish_o === 1'b1) begin
            fin_cnt[f]++;
          end
          if (e_last) begin
            report_frame(f);
          end
        end
      end else if (code_valid_o !== 1'b0 || finish_o !== 1'b0) begin
        errors++;
        $display("Output flags are not low while idle at %0t", $time);
      end
    end
  end

  initial begin
    int waited;
    clk           = 1'b0;
    rst_n         = 1'b0;
    pixel_i       = '0;
    pixel_valid_i = 1'b0;
    img_size_i    = SIZE_W'(5);
    seed          = 52;
    checks        = 0;
    errors        = 0;
    err_base      = 0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      out_cnt[f] = 0;
      fin_cnt[f] = 0;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    for (int f = 0; f < NUM_FRAMES; f++) begin
      run_frame(f);
    end
    @(posedge clk);
    pixel_valid_i <= 1'b0;
    waited = 0;
    while (exp_ni.size() > 0 && waited < DRAIN_MAX) begin
      @(posedge clk);
      waited++;
    end
    if (exp_ni.size() > 0) begin
      errors++;
      $display("Timed out waiting for %0d codes that never came out", exp_ni.size());
    end
    // Idle tail so stray outputs are still caught.
    repeat (10) @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- sim.f
verilog/nird_pkg.sv
verilog/nird_line_buffer.sv
verilog/nird_window.sv
verilog/nird_ring_sampler.sv
verilog/nird_pattern.sv
verilog/nird_riu2.sv
verilog/nird_top.sv
dv/nird_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module nird_tb -f sim.f -o nird_sim \
  && ./obj_dir/nird_sim | tee /dev/stderr | grep -q "Everything OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
